//--- verilog/obj_settings.svh
// ========================================
// Sizes of the object layer
// ROM_AW must equal bank bits plus offset bits
// ========================================
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// Entries in the object table
`define OBJ_COUNT 16

// 16-bit words per table entry
`define OBJ_WORDS 4

// Visible pixels per scanline
`define LINE_WIDTH 320

// Pixels in one object row
`define OBJ_WIDTH 16

// Graphics ROM word address
`define ROM_AW 20

`endif

//--- verilog/obj_table_pkg.sv
// ========================================
// Entry layout is four words per object
// Bottom line is exclusive
// ========================================
`include "obj_settings.svh"

package obj_table_pkg;

    // Entry number on top, word index below
    typedef logic [$clog2(`OBJ_COUNT*`OBJ_WORDS)-1:0] tbl_addr_t;
    typedef logic [15:0] obj_word_t;

    // Draw command fields
    typedef logic [15:0] gfx_offset_t;
    typedef logic [3:0]  gfx_bank_t;
    typedef logic [1:0]  obj_prio_t;
    typedef logic [5:0]  obj_pal_t;

    // Word 0 has bottom in [15:8] and top in [7:0]
    localparam int unsigned W_RANGE = 0;
    // Word 1 has hflip in bit 15 and x in [8:0]
    localparam int unsigned W_XPOS  = 1;
    // Word 2 is the graphics offset
    localparam int unsigned W_GFX   = 2;
    // Word 3 has prio [15:14], palette [13:8], bank [7:4]
    localparam int unsigned W_ATTR  = 3;

endpackage

//--- verilog/obj_video_pkg.sv
// ========================================
// Pixel color 0 is transparent everywhere
// ========================================

package obj_video_pkg;

    // Horizontal position, covers a 512-pixel span
    typedef logic [8:0] xpos_t;

    // Scanline number
    typedef logic [7:0] vline_t;

    // Line buffer word
    // Priority [11:10], palette [9:4], color [3:0]
    typedef logic [11:0] obj_pixel_t;

    // Four 4-bit pixels
    // Leftmost pixel in the top nibble
    typedef logic [15:0] gfx_word_t;

    // Empty buffer location
    localparam obj_pixel_t PIXEL_NONE = 12'h000;

endpackage

//--- verilog/obj_ram.sv
// ========================================
// Both read ports have one cycle latency
// CPU writes need at least one byte lane
// ========================================
`timescale 1ns/10ps

module obj_ram (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cpu_cs,
    input  logic                     cpu_we,
    input  obj_table_pkg::tbl_addr_t cpu_addr,
    input  obj_table_pkg::obj_word_t cpu_dout,
    input  logic [1:0]               dsn,
    input  obj_table_pkg::tbl_addr_t tbl_addr,
    output obj_table_pkg::obj_word_t cpu_din,
    output obj_table_pkg::obj_word_t tbl_dout
);
    import obj_table_pkg::*;

    localparam int DEPTH = 2 ** $bits(tbl_addr_t);

    obj_word_t mem [DEPTH];
    logic      wr;

    // CPU write strobe
    assign wr = cpu_cs && cpu_we;

    always_ff @(posedge clk) begin
        // Upper byte lane, dsn[1] low
        if (wr && !dsn[1]) begin
            mem[cpu_addr][15:8] <= cpu_dout[15:8];
        end
        // Lower byte lane, dsn[0] low
        if (wr && !dsn[0]) begin
            mem[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        // Old data on a write cycle
        cpu_din  <= mem[cpu_addr];
        // Scanner port
        tbl_dout <= mem[tbl_addr];
    end

    // A CPU write must select a byte lane
    a_write_lane: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> (dsn != 2'b11));

endmodule

//--- verilog/obj_scan.sv
// ========================================
// One table walk per line, restarted at hstart
// ========================================
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_scan (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hstart,
    input  obj_video_pkg::vline_t      vrender,
    input  obj_table_pkg::obj_word_t   tbl_dout,
    input  logic                       busy,
    output obj_table_pkg::tbl_addr_t   tbl_addr,
    output logic                       dr_start,
    output obj_video_pkg::xpos_t       dr_xpos,
    output logic                       dr_hflip,
    output obj_table_pkg::gfx_offset_t dr_offset,
    output obj_table_pkg::gfx_bank_t   dr_bank,
    output obj_table_pkg::obj_prio_t   dr_prio,
    output obj_table_pkg::obj_pal_t    dr_pal,
    output logic [3:0]                 dr_row
);
    import obj_table_pkg::*;

    localparam int IDX_W = $clog2(`OBJ_COUNT);

    typedef enum logic [2:0] {
        S_IDLE, S_W0, S_CHK, S_READ, S_LAST, S_ISSUE
    } state_t;

    state_t           st;
    logic [IDX_W-1:0] idx;
    logic [1:0]       widx;
    logic [1:0]       wsel_q;
    logic             fetch_q;
    obj_word_t        xpos_w;
    obj_word_t        gfx_w;
    obj_word_t        attr_w;
    logic             covers;
    logic             last;

    assign tbl_addr = {idx, widx};
    // Top inclusive, bottom exclusive
    assign covers = (vrender >= tbl_dout[7:0]) && (vrender < tbl_dout[15:8]);
    assign last = idx == IDX_W'(`OBJ_COUNT - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st       <= S_IDLE;
            idx      <= '0;
            widx     <= 2'(W_RANGE);
            dr_start <= 1'b0;
        end else if (hstart) begin
            // New line, walk again from entry 0
            st       <= S_W0;
            idx      <= '0;
            widx     <= 2'(W_RANGE);
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            case (st)
                // Word 0 address out
                S_W0: st <= S_CHK;
                S_CHK: begin
                    if (covers) begin
                        widx <= 2'(W_XPOS);
                        st   <= S_READ;
                    end else if (last) begin
                        st <= S_IDLE;
                    end else begin
                        idx <= idx + 1'b1;
                        st  <= S_W0;
                    end
                end
                // Words 1 to 3, wraps back to word 0
                S_READ: begin
                    widx <= widx + 2'd1;
                    if (widx == 2'(W_ATTR)) begin
                        st <= S_LAST;
                    end
                end
                // Word 3 lands this cycle
                S_LAST: st <= S_ISSUE;
                S_ISSUE: begin
                    if (!busy) begin
                        dr_start <= 1'b1;
                        if (last) begin
                            st <= S_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                            st  <= S_W0;
                        end
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // Entry capture, one cycle behind the address
    always_ff @(posedge clk) begin
        fetch_q <= st == S_READ;
        wsel_q  <= widx;
        if (st == S_CHK) begin
            dr_row <= 4'(vrender - tbl_dout[7:0]);
        end
        if (fetch_q) begin
            case (wsel_q)
                2'(W_XPOS): xpos_w <= tbl_dout;
                2'(W_GFX):  gfx_w  <= tbl_dout;
                2'(W_ATTR): attr_w <= tbl_dout;
                default: ;
            endcase
        end
    end

    // Field split of words 1 and 3
    assign dr_xpos   = xpos_w[8:0];
    assign dr_hflip  = xpos_w[15];
    assign dr_offset = gfx_w;
    assign dr_prio   = attr_w[15:14];
    assign dr_pal    = attr_w[13:8];
    assign dr_bank   = attr_w[7:4];

    // Drawer must be idle whenever a command goes out
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        dr_start |-> !busy);

endmodule

//--- verilog/obj_draw.sv
// ========================================
// One 16-pixel row per command, four ROM words
// hstart abandons a draw in progress
// ========================================
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_draw (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hstart,
    input  logic                       start,
    input  obj_video_pkg::xpos_t       xpos,
    input  logic                       hflip,
    input  obj_table_pkg::gfx_offset_t offset,
    input  obj_table_pkg::gfx_bank_t   bank,
    input  obj_table_pkg::obj_prio_t   prio,
    input  obj_table_pkg::obj_pal_t    pal,
    input  logic [3:0]                 row,
    input  logic                       gfx_ok,
    input  obj_video_pkg::gfx_word_t   gfx_data,
    output logic                       busy,
    output logic                       gfx_cs,
    output logic [`ROM_AW-1:0]         gfx_addr,
    output logic                       bf_we,
    output obj_video_pkg::xpos_t       bf_addr,
    output obj_video_pkg::obj_pixel_t  bf_data
);
    import obj_table_pkg::*;
    import obj_video_pkg::*;

    localparam int ROW_WORDS = `OBJ_WIDTH / 4;
    localparam int WORD_W    = $clog2(ROW_WORDS);
    localparam int PIX_W     = $clog2(`OBJ_WIDTH);

    // Command copy
    xpos_t       x_q;
    logic        hflip_q;
    gfx_offset_t offset_q;
    gfx_bank_t   bank_q;
    obj_prio_t   prio_q;
    obj_pal_t    pal_q;
    logic [3:0]  row_q;

    gfx_word_t         pix_q;
    logic [WORD_W-1:0] w;
    logic [1:0]        k;
    logic              writing;
    gfx_offset_t       word_addr;
    logic [PIX_W-1:0]  pidx;
    logic [9:0]        xsum;
    logic [3:0]        color;

    // Row base plus word within the row
    assign word_addr = offset_q + gfx_offset_t'(row_q * ROW_WORDS) + gfx_offset_t'(w);
    assign gfx_addr  = {bank_q, word_addr};

    // Pixel index within the row, mirrored by hflip
    assign pidx  = hflip_q ? ~{w, k} : {w, k};
    // One extra bit so clipping sees the carry
    assign xsum  = {1'b0, x_q} + 10'(pidx);
    // Nibble k, leftmost first
    assign color = pix_q[{~k, 2'b00} +: 4];

    // Skip transparent and off-line pixels
    assign bf_we   = writing && (color != 4'd0) && (xsum < 10'(`LINE_WIDTH));
    assign bf_addr = xsum[8:0];
    assign bf_data = {prio_q, pal_q, color};

    always_ff @(posedge clk) begin
        if (!rst_n || hstart) begin
            busy    <= 1'b0;
            gfx_cs  <= 1'b0;
            writing <= 1'b0;
            w       <= '0;
            k       <= '0;
        end else if (start) begin
            busy   <= 1'b1;
            gfx_cs <= 1'b1;
            w      <= '0;
        end else if (gfx_cs) begin
            // Hold the request until the ROM answers
            if (gfx_ok) begin
                gfx_cs  <= 1'b0;
                writing <= 1'b1;
                k       <= '0;
            end
        end else if (writing) begin
            k <= k + 2'd1;
            if (k == 2'd3) begin
                writing <= 1'b0;
                if (w == WORD_W'(ROW_WORDS - 1)) begin
                    busy <= 1'b0;
                end else begin
                    w      <= w + 1'b1;
                    gfx_cs <= 1'b1;
                end
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (start) begin
            x_q      <= xpos;
            hflip_q  <= hflip;
            offset_q <= offset;
            bank_q   <= bank;
            prio_q   <= prio;
            pal_q    <= pal;
            row_q    <= row;
        end
        if (gfx_cs && gfx_ok) begin
            pix_q <= gfx_data;
        end
    end

    // Request and address hold until the ROM accepts
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (gfx_cs && !gfx_ok && !hstart) |=> (gfx_cs && $stable(gfx_addr)));

endmodule

//--- verilog/obj_line_buffer.sv
// ========================================
// Two banks swap at hstart
// Playout erases each location it reads
// ========================================
`timescale 1ns/10ps

module obj_line_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      hstart,
    input  logic                      lhbl,
    input  logic                      pxl_cen,
    input  logic                      bf_we,
    input  obj_video_pkg::xpos_t      bf_addr,
    input  obj_video_pkg::obj_pixel_t bf_data,
    output obj_video_pkg::obj_pixel_t pxl
);
    import obj_video_pkg::*;

    localparam int DEPTH = 2 ** $bits(xpos_t);

    // Bank being drawn, the other one plays out
    logic       draw_sel;
    xpos_t      rd_cnt;
    logic       rd_en;
    obj_pixel_t rd_data [2];

    assign rd_en = lhbl && pxl_cen;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        obj_pixel_t mem [DEPTH];
        logic       drawing;

        assign drawing = draw_sel == 1'(b);

        // One write port per bank
        always_ff @(posedge clk) begin
            if (drawing) begin
                if (bf_we) begin
                    mem[bf_addr] <= bf_data;
                end
            end else if (rd_en) begin
                // Clear behind the read
                mem[rd_cnt] <= PIXEL_NONE;
            end
        end

        assign rd_data[b] = mem[rd_cnt];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            draw_sel <= 1'b0;
            rd_cnt   <= '0;
            pxl      <= PIXEL_NONE;
        end else begin
            if (hstart) begin
                draw_sel <= ~draw_sel;
                rd_cnt   <= '0;
            end else if (rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            // Pixel out one cycle after its enable
            if (rd_en) begin
                pxl <= rd_data[~draw_sel];
            end
        end
    end

endmodule

//--- verilog/obj_layer.sv
// ========================================
// Objects drawn in line N show after the next hstart
// ========================================
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_layer (
    input  logic                      clk,
    input  logic                      rst_n,
    // CPU side
    input  logic                      cpu_cs,
    input  logic                      cpu_we,
    input  obj_table_pkg::tbl_addr_t  cpu_addr,
    input  obj_table_pkg::obj_word_t  cpu_dout,
    input  logic [1:0]                dsn,
    output obj_table_pkg::obj_word_t  cpu_din,
    // Graphics ROM
    input  logic                      gfx_ok,
    output logic                      gfx_cs,
    output logic [`ROM_AW-1:0]        gfx_addr,
    input  obj_video_pkg::gfx_word_t  gfx_data,
    // Video timing
    input  logic                      hstart,
    input  obj_video_pkg::vline_t     vrender,
    input  logic                      lhbl,
    input  logic                      pxl_cen,
    output obj_video_pkg::obj_pixel_t pxl
);
    import obj_table_pkg::*;
    import obj_video_pkg::*;

    // Table to scanner
    tbl_addr_t   tbl_addr;
    obj_word_t   tbl_dout;

    // Scanner to drawer
    logic        dr_start;
    logic        dr_busy;
    xpos_t       dr_xpos;
    logic        dr_hflip;
    gfx_offset_t dr_offset;
    gfx_bank_t   dr_bank;
    obj_prio_t   dr_prio;
    obj_pal_t    dr_pal;
    logic [3:0]  dr_row;

    // Drawer to line buffer
    logic        bf_we;
    xpos_t       bf_addr;
    obj_pixel_t  bf_data;

    obj_ram u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_cs   (cpu_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .tbl_addr (tbl_addr),
        .cpu_din  (cpu_din),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .hstart    (hstart),
        .vrender   (vrender),
        .tbl_dout  (tbl_dout),
        .busy      (dr_busy),
        .tbl_addr  (tbl_addr),
        .dr_start  (dr_start),
        .dr_xpos   (dr_xpos),
        .dr_hflip  (dr_hflip),
        .dr_offset (dr_offset),
        .dr_bank   (dr_bank),
        .dr_prio   (dr_prio),
        .dr_pal    (dr_pal),
        .dr_row    (dr_row)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst_n    (rst_n),
        .hstart   (hstart),
        .start    (dr_start),
        .xpos     (dr_xpos),
        .hflip    (dr_hflip),
        .offset   (dr_offset),
        .bank     (dr_bank),
        .prio     (dr_prio),
        .pal      (dr_pal),
        .row      (dr_row),
        .gfx_ok   (gfx_ok),
        .gfx_data (gfx_data),
        .busy     (dr_busy),
        .gfx_cs   (gfx_cs),
        .gfx_addr (gfx_addr),
        .bf_we    (bf_we),
        .bf_addr  (bf_addr),
        .bf_data  (bf_data)
    );

    obj_line_buffer u_line (
        .clk     (clk),
        .rst_n   (rst_n),
        .hstart  (hstart),
        .lhbl    (lhbl),
        .pxl_cen (pxl_cen),
        .bf_we   (bf_we),
        .bf_addr (bf_addr),
        .bf_data (bf_data),
        .pxl     (pxl)
    );

endmodule

//--- dv/gfx_rom_model.sv
// ========================================
// Latency 0 to 3 cycles, picked per request
// ========================================
`timescale 1ns/10ps
`include "obj_settings.svh"

module gfx_rom_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     gfx_cs,
    input  logic [`ROM_AW-1:0]       gfx_addr,
    output logic                     gfx_ok,
    output obj_video_pkg::gfx_word_t gfx_data
);
    logic [1:0] cnt;

    // Content hash, matched by the testbench reference
    function automatic logic [15:0] word_at(input logic [`ROM_AW-1:0] a);
        logic [31:0] h;
        h = {12'h000, a} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[15:0];
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            gfx_ok   <= 1'b0;
            gfx_data <= '0;
            cnt      <= 2'd0;
        end else if (!gfx_cs || gfx_ok) begin
            // Idle or just answered, pick the next latency
            gfx_ok <= 1'b0;
            cnt    <= 2'($urandom_range(0, 3));
        end else if (cnt == 2'd0) begin
            gfx_ok   <= 1'b1;
            gfx_data <= word_at(gfx_addr);
        end else begin
            cnt <= cnt - 2'd1;
        end
    end

endmodule

//--- dv/obj_layer_tb.sv
// ========================================
// Lines of 400 cycles, 320 active, pxl_cen always on
// At most six objects per random table so draws fit a line
// ========================================
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_layer_tb;
    import obj_table_pkg::*;
    import obj_video_pkg::*;

    localparam int N_LINES = 29;
    localparam int CYCLE_LIMIT = N_LINES * 400 * 2;

    logic               clk;
    logic               rst_n;
    logic               cpu_cs;
    logic               cpu_we;
    logic               gfx_ok;
    logic               gfx_cs;
    logic               hstart;
    logic               lhbl;
    logic               pxl_cen;
    tbl_addr_t          cpu_addr;
    obj_word_t          cpu_dout;
    obj_word_t          cpu_din;
    logic [1:0]         dsn;
    logic [`ROM_AW-1:0] gfx_addr;
    gfx_word_t          gfx_data;
    vline_t             vrender;
    obj_pixel_t         pxl;

    obj_word_t  shadow [64];
    obj_pixel_t exp_draw [`LINE_WIDTH];
    obj_pixel_t exp_play [`LINE_WIDTH];
    logic       draw_valid;
    logic       play_valid;
    logic       rd_q;
    int         px;
    int         x_q;
    int         cycles;
    int         pixel_errors;
    int         word_errors;

    obj_layer uut (.*);

    gfx_rom_model u_rom (
        .clk      (clk),
        .rst_n    (rst_n),
        .gfx_cs   (gfx_cs),
        .gfx_addr (gfx_addr),
        .gfx_ok   (gfx_ok),
        .gfx_data (gfx_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Same hash as the ROM model holds
    function automatic logic [15:0] rom_word(input logic [`ROM_AW-1:0] a);
        logic [31:0] h;
        h = {12'h000, a} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[15:0];
    endfunction

    // Expected line from the table copy
    function automatic void build_expected(input vline_t v);
        obj_word_t   w0;
        obj_word_t   w1;
        obj_word_t   w2;
        obj_word_t   w3;
        logic [3:0]  row;
        logic [3:0]  color;
        logic [15:0] word;
        int          i;
        int          x;
        for (int p = 0; p < `LINE_WIDTH; p++) exp_draw[p] = '0;
        // Later entries overwrite earlier ones
        for (int e = 0; e < `OBJ_COUNT; e++) begin
            w0 = shadow[e*4];
            w1 = shadow[e*4+1];
            w2 = shadow[e*4+2];
            w3 = shadow[e*4+3];
            if (v >= w0[7:0] && v < w0[15:8]) begin
                row = 4'(v - w0[7:0]);
                for (int w = 0; w < 4; w++) begin
                    word = rom_word({w3[7:4], 16'(w2 + 16'(row) * 16'd4 + 16'(w))});
                    for (int k = 0; k < 4; k++) begin
                        color = word[(15 - 4*k) -: 4];
                        i = 4*w + k;
                        if (w1[15]) i = 15 - i;
                        x = int'(w1[8:0]) + i;
                        if (color != 4'd0 && x < `LINE_WIDTH)
                            exp_draw[x] = {w3[15:14], w3[13:8], color};
                    end
                end
            end
        end
    endfunction

    task automatic check_pixel(input obj_pixel_t got, input obj_pixel_t exp, input int x);
        if (got !== exp) begin
            pixel_errors++;
            $display("MISMATCH at %0t: pixel x=%0d got %h expected %h", $time, x, got, exp);
        end
    endtask

    task automatic check_word(input obj_word_t got, input obj_word_t exp, input tbl_addr_t a);
        if (got !== exp) begin
            word_errors++;
            $display("MISMATCH at %0t: table word %0d got %h expected %h", $time, a, got, exp);
        end
    endtask

    task automatic write_word(input tbl_addr_t a, input obj_word_t d, input logic [1:0] lanes);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_dout = d;
        dsn      = lanes;
        @(negedge clk);
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
        dsn    = 2'b11;
    endtask

    task automatic read_word(input tbl_addr_t a, input obj_word_t exp);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_addr = a;
        @(negedge clk);
        cpu_cs = 1'b0;
        check_word(cpu_din, exp, a);
    endtask

    task automatic set_entry(input int e, input obj_word_t w0, input obj_word_t w1,
                             input obj_word_t w2, input obj_word_t w3);
        shadow[e*4]   = w0;
        shadow[e*4+1] = w1;
        shadow[e*4+2] = w2;
        shadow[e*4+3] = w3;
        for (int w = 0; w < 4; w++) write_word(tbl_addr_t'(e*4 + w), shadow[e*4+w], 2'b00);
    endtask

    task automatic clear_table();
        for (int e = 0; e < `OBJ_COUNT; e++) set_entry(e, '0, '0, '0, '0);
    endtask

    // One line of 400 cycles with 320 active
    task automatic run_line(input vline_t v, input logic chk);
        @(negedge clk);
        exp_play   = exp_draw;
        play_valid = draw_valid;
        build_expected(v);
        draw_valid = chk;
        hstart  = 1'b1;
        vrender = v;
        for (int c = 1; c < 400; c++) begin
            @(negedge clk);
            hstart = 1'b0;
            lhbl   = (c <= `LINE_WIDTH);
        end
    endtask

    task automatic random_table(input int v0);
        int active;
        logic [7:0] top;
        active = 0;
        clear_table();
        for (int e = 0; e < `OBJ_COUNT; e++) begin
            if (active < 6 && $urandom_range(0, 2) == 0) begin
                active++;
                top = 8'(v0 - int'($urandom_range(0, 15)));
                set_entry(e, {8'(top + 8'($urandom_range(1, 16))), top},
                          {1'($urandom_range(0, 1)), 6'd0, 9'($urandom_range(0, 330))},
                          16'($urandom), 16'($urandom));
            end
        end
    endtask

    // Track the playout position
    always @(posedge clk) begin
        if (hstart) px <= 0;
        else if (lhbl && pxl_cen) px <= px + 1;
        rd_q <= lhbl && pxl_cen && !hstart;
        x_q  <= px;
    end

    // Compare each played pixel at the falling edge
    always @(negedge clk) begin
        if (rd_q && play_valid) check_pixel(pxl, exp_play[x_q], x_q);
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int v0;
        void'($urandom(32'h0a84_ab5f));
        rst_n = 1'b0;
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        hstart = 1'b0;
        vrender = '0;
        lhbl = 1'b0;
        pxl_cen = 1'b1;
        draw_valid = 1'b0;
        play_valid = 1'b0;
        cycles = 0;
        pixel_errors = 0;
        word_errors = 0;
        for (int p = 0; p < `LINE_WIDTH; p++) exp_draw[p] = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Byte lane writes and readback
        write_word(6'd9, 16'h0000, 2'b00);
        read_word(6'd9, 16'h0000);
        write_word(6'd9, 16'ha5c3, 2'b01);
        read_word(6'd9, 16'ha500);
        write_word(6'd9, 16'h5a3c, 2'b10);
        read_word(6'd9, 16'ha53c);
        write_word(6'd9, 16'h1234, 2'b00);
        read_word(6'd9, 16'h1234);

        // Two empty lines flush both banks
        clear_table();
        run_line(8'd0, 1'b0);
        run_line(8'd0, 1'b0);

        // Single object without flip
        set_entry(0, {8'd20, 8'd10}, 16'd40, 16'h0100, {2'd1, 6'd5, 4'd2, 4'd0});
        run_line(8'd12, 1'b1);
        // Flip and overlap
        set_entry(0, {8'd20, 8'd10}, 16'h8000 | 16'd40, 16'h0100, {2'd1, 6'd5, 4'd2, 4'd0});
        set_entry(1, {8'd16, 8'd4}, 16'd48, 16'h0230, {2'd3, 6'd9, 4'd7, 4'd0});
        run_line(8'd12, 1'b1);
        // Objects clipped at the line end
        // Entry 3 would wrap onto x 0 to 7 without the clip
        set_entry(2, {8'd13, 8'd12}, 16'd312, 16'h0777, {2'd2, 6'd33, 4'd1, 4'd0});
        set_entry(3, {8'd13, 8'd12}, 16'd504, 16'h0555, {2'd0, 6'd17, 4'd3, 4'd0});
        run_line(8'd12, 1'b1);
        // Line outside all ranges
        run_line(8'd25, 1'b1);

        // Four lines per random table
        for (int t = 0; t < 5; t++) begin
            v0 = int'($urandom_range(16, 200));
            random_table(v0);
            for (int n = 0; n < 4; n++) run_line(8'(v0 + n), 1'b1);
        end

        // Empty line after a busy one
        run_line(8'd255, 1'b1);
        run_line(8'd255, 1'b1);
        run_line(8'd255, 1'b0);

        $display("Errors: pixel %0d, table word %0d", pixel_errors, word_errors);
        if (pixel_errors == 0 && word_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/obj_table_pkg.sv
verilog/obj_video_pkg.sv
verilog/obj_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_layer.sv
dv/gfx_rom_model.sv
dv/obj_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the object layer testbench with Verilator
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module obj_layer_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vobj_layer_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
